// File: verilog/mem_req_defs.svh
`ifndef MEM_REQ_DEFS_SVH
`define MEM_REQ_DEFS_SVH

// ----------------------------------------
// client side
// ----------------------------------------

// client byte address
`define ADDR_W 19
// bytes per sram line, also the client data bus
`define LINE_BYTES 32
// byte offset inside a line
`define OFFSET_W 5
// request size in bytes, 1 to 32
`define SIZE_W 6

// ----------------------------------------
// bank geometry
// ----------------------------------------

`define NUM_BANKS 16
`define BANK_W 4
// line index inside one bank, address bits 15..6
`define LINE_ADDR_W 10
// odd or even bank of a region
`define BANK_LO_BIT 5
// region field, top of the address
`define REGION_HI 18
`define REGION_LO 16

`endif

// File: verilog/mem_req_pkg.sv
`include "mem_req_defs.svh"

package mem_req_pkg;

	// one sram line, byte 0 in the low bits
	typedef logic [`LINE_BYTES-1:0][7:0] line_t;

	// client request, held as a level
	typedef struct packed {
		logic rd_req;
		logic wr_req;
		logic [`ADDR_W-1:0] addr;
		logic [`SIZE_W-1:0] size;
		line_t wdata;
	} client_req_t;

	// client response, single cycle pulses
	typedef struct packed {
		logic rd_valid;
		line_t rd_data;
		logic wr_ack;
	} client_rsp_t;

	// one line of an access
	typedef struct packed {
		logic [`BANK_W-1:0] bank;
		logic [`LINE_ADDR_W-1:0] line_addr;
		logic [`LINE_BYTES-1:0] byte_en;
		line_t wdata;
	} line_access_t;

	// registered request, one or two lines
	typedef struct packed {
		logic is_write;
		logic split;
		logic [`OFFSET_W-1:0] offset;
		logic [`SIZE_W-1:0] size;
		line_access_t first;
		line_access_t second;
	} access_plan_t;

	// command to one bank, valid while cs is high
	typedef struct packed {
		logic cs;
		logic read;
		logic write;
		logic [`LINE_ADDR_W-1:0] line_addr;
		line_t wdata;
		logic [`LINE_BYTES-1:0] byte_en;
	} bank_cmd_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_ONE,
		READ_TWO,
		WRITE_ONE,
		WRITE_TWO,
		READ_WAIT,
		FINISH
	} req_state_e;

endpackage

// File: verilog/access_planner.sv
`timescale 1ns/1ps
`include "mem_req_defs.svh"

module access_planner (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_req_pkg::client_req_t  req,
	input  logic                      accept,
	output mem_req_pkg::access_plan_t plan
);

	// ----------------------------------------
	// address decode
	// ----------------------------------------

	logic [`OFFSET_W-1:0] offset;
	// first byte past the request, counted from line start
	logic [`SIZE_W-1:0] end_pos;
	logic split;
	// address of the following line
	logic [`ADDR_W-1:0] next_addr;
	// bytes of the first line, used to pull the tail down
	logic [`SIZE_W-1:0] tail_shift;
	mem_req_pkg::access_plan_t plan_d;

	assign offset = req.addr[`OFFSET_W-1:0];
	// max 31 + 32, still fits the size width
	assign end_pos = `SIZE_W'(offset) + req.size;
	assign split = end_pos > `SIZE_W'(`LINE_BYTES);
	// carry may run into the region bits
	assign next_addr = req.addr + `ADDR_W'(`LINE_BYTES);
	assign tail_shift = `SIZE_W'(`LINE_BYTES) - `SIZE_W'(offset);

	// ----------------------------------------
	// per line access
	// ----------------------------------------

	always_comb begin
		// read wins when both are up
		plan_d.is_write = !req.rd_req;
		plan_d.split = split;
		plan_d.offset = offset;
		plan_d.size = req.size;

		// bank is region then parity bit
		plan_d.first.bank = {req.addr[`REGION_HI:`REGION_LO], req.addr[`BANK_LO_BIT]};
		plan_d.first.line_addr = req.addr[`BANK_LO_BIT+`LINE_ADDR_W:`BANK_LO_BIT+1];
		// client byte 0 lands on the offset
		plan_d.first.wdata = req.wdata << {offset, 3'b000};

		// second line, same decode on addr + 32
		plan_d.second.bank = {next_addr[`REGION_HI:`REGION_LO], next_addr[`BANK_LO_BIT]};
		plan_d.second.line_addr = next_addr[`BANK_LO_BIT+`LINE_ADDR_W:`BANK_LO_BIT+1];
		// remaining client bytes start at line byte 0
		plan_d.second.wdata = req.wdata >> {tail_shift, 3'b000};

		for (int i = 0; i < `LINE_BYTES; i++) begin
			// offset up to end of request or end of line
			plan_d.first.byte_en[i] = (i >= offset) && (i < end_pos);
			// only the overflow past byte 31
			plan_d.second.byte_en[i] = split && (i + `LINE_BYTES < end_pos);
		end
	end

	// ----------------------------------------
	// plan register
	// ----------------------------------------

	// loaded once per request, held until the next accept
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			plan <= '0;
		end else if (accept) begin
			plan <= plan_d;
		end
	end

endmodule

// File: verilog/req_sequencer.sv
`timescale 1ns/1ps
`include "mem_req_defs.svh"

module req_sequencer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_req_pkg::client_req_t  req,
	input  mem_req_pkg::access_plan_t plan,
	input  logic [`NUM_BANKS-1:0]     gnt,
	output logic                      accept,
	output logic [`NUM_BANKS-1:0]     bank_req,
	output logic [1:0]                line_gnt,
	output logic                      wr_ack
);

	mem_req_pkg::req_state_e state;
	mem_req_pkg::req_state_e next_state;
	// one flag per line still waiting for its grant
	logic [1:0] pend;
	// incoming request runs past the end of its line
	logic crosses;
	logic all_granted;

	// planner split rule applied to the raw request before the plan loads
	assign crosses = (`SIZE_W'(req.addr[`OFFSET_W-1:0]) + req.size) > `SIZE_W'(`LINE_BYTES);
	assign accept = (state == mem_req_pkg::IDLE) && (req.rd_req || req.wr_req);

	// ----------------------------------------
	// bank requests and grants
	// ----------------------------------------

	always_comb begin
		bank_req = '0;
		if (pend[0]) begin
			bank_req[plan.first.bank] = 1'b1;
		end
		if (pend[1]) begin
			bank_req[plan.second.bank] = 1'b1;
		end
	end

	// grant pulse seen by the line that asked for it
	assign line_gnt[0] = pend[0] && gnt[plan.first.bank];
	assign line_gnt[1] = pend[1] && gnt[plan.second.bank];
	// nothing left once this cycle's grants land
	assign all_granted = (pend & ~line_gnt) == 2'b00;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend <= 2'b00;
		end else if (accept) begin
			pend <= {crosses, 1'b1};
		end else begin
			pend <= pend & ~line_gnt;
		end
	end

	// ----------------------------------------
	// FSM
	// ----------------------------------------

	always_comb begin
		next_state = state;
		case (state)
			mem_req_pkg::IDLE: begin
				if (req.rd_req) begin
					next_state = crosses ? mem_req_pkg::READ_TWO : mem_req_pkg::READ_ONE;
				end else if (req.wr_req) begin
					next_state = crosses ? mem_req_pkg::WRITE_TWO : mem_req_pkg::WRITE_ONE;
				end
			end
			mem_req_pkg::READ_ONE, mem_req_pkg::READ_TWO: begin
				// data comes back one cycle after the grant
				if (all_granted) begin
					next_state = mem_req_pkg::READ_WAIT;
				end
			end
			mem_req_pkg::WRITE_ONE, mem_req_pkg::WRITE_TWO: begin
				if (all_granted) begin
					next_state = mem_req_pkg::FINISH;
				end
			end
			mem_req_pkg::READ_WAIT: next_state = mem_req_pkg::FINISH;
			// response pulse cycle with requests ignored
			mem_req_pkg::FINISH: next_state = mem_req_pkg::IDLE;
			default: next_state = mem_req_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mem_req_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// write ack one cycle after the last write grant
	assign wr_ack = (state == mem_req_pkg::FINISH) && plan.is_write;

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// a requested bank stays requested until the arbiter grants it
	assert property (@(posedge clk) disable iff (!rst_n)
		($past(bank_req & ~gnt) & ~bank_req) == '0)
		else $error("ERROR %0t: bank request dropped before grant", $time);

	// arbiter only grants banks that are asked for
	assert property (@(posedge clk) disable iff (!rst_n) (gnt & ~bank_req) == '0)
		else $error("ERROR %0t: grant to a bank without request", $time);

endmodule

// File: verilog/read_realign.sv
`timescale 1ns/1ps
`include "mem_req_defs.svh"

module read_realign (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  mem_req_pkg::access_plan_t             plan,
	input  logic [1:0]                            line_gnt,
	input  mem_req_pkg::line_t [`NUM_BANKS-1:0]   bank_rdata,
	output logic                                  rd_valid,
	output mem_req_pkg::line_t                    rd_data
);

	// grant delayed to the data return cycle
	logic [1:0] gnt_d;
	// lines already returned for this request
	logic [1:0] seen;
	logic [1:0] have;
	logic [1:0] need;
	logic last_line;
	mem_req_pkg::line_t hold_lo;
	mem_req_pkg::line_t hold_hi;
	mem_req_pkg::line_t line_lo;
	mem_req_pkg::line_t line_hi;
	logic [2*`LINE_BYTES-1:0][7:0] pair_shift;
	mem_req_pkg::line_t aligned;

	assign need = {plan.split, 1'b1};
	assign have = seen | gnt_d;
	assign last_line = (gnt_d != 2'b00) && (have == need);

	// ----------------------------------------
	// line capture
	// ----------------------------------------

	// fresh data wins over the held copy
	assign line_lo = gnt_d[0] ? bank_rdata[plan.first.bank] : hold_lo;
	assign line_hi = gnt_d[1] ? bank_rdata[plan.second.bank] : hold_hi;

	always_ff @(posedge clk) begin
		if (gnt_d[0]) begin
			hold_lo <= bank_rdata[plan.first.bank];
		end
		if (gnt_d[1]) begin
			hold_hi <= bank_rdata[plan.second.bank];
		end
	end

	// ----------------------------------------
	// shift down and trim
	// ----------------------------------------

	always_comb begin
		pair_shift = {line_hi, line_lo} >> {plan.offset, 3'b000};
		// bytes at and past size read as zero
		for (int i = 0; i < `LINE_BYTES; i++) begin
			aligned[i] = (i < plan.size) ? pair_shift[i] : 8'h00;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_d <= 2'b00;
			seen <= 2'b00;
			rd_valid <= 1'b0;
		end else begin
			gnt_d <= line_gnt;
			// writes run through too, they just never raise valid
			if (gnt_d != 2'b00) begin
				seen <= last_line ? 2'b00 : have;
			end
			rd_valid <= last_line && !plan.is_write;
		end
	end

	always_ff @(posedge clk) begin
		if (last_line) begin
			rd_data <= aligned;
		end
	end

endmodule

// File: verilog/bank_port_mux.sv
`timescale 1ns/1ps
`include "mem_req_defs.svh"

module bank_port_mux (
	input  mem_req_pkg::access_plan_t                plan,
	input  logic [1:0]                               line_gnt,
	output mem_req_pkg::bank_cmd_t [`NUM_BANKS-1:0]  bank_cmd
);

	// both lines of the plan, indexed by line
	mem_req_pkg::line_access_t acc [2];

	assign acc[0] = plan.first;
	assign acc[1] = plan.second;

	// ----------------------------------------
	// command steering
	// ----------------------------------------

	always_comb begin
		// banks without a grant stay idle
		bank_cmd = '0;
		for (int l = 0; l < 2; l++) begin
			if (line_gnt[l]) begin
				bank_cmd[acc[l].bank].cs = 1'b1;
				bank_cmd[acc[l].bank].read = !plan.is_write;
				bank_cmd[acc[l].bank].write = plan.is_write;
				bank_cmd[acc[l].bank].line_addr = acc[l].line_addr;
				// data and enables only matter on a write
				bank_cmd[acc[l].bank].wdata = acc[l].wdata;
				bank_cmd[acc[l].bank].byte_en = acc[l].byte_en;
			end
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// two lines of one request sit in different banks,
	// otherwise one command would overwrite the other
	always_comb begin
		if ((line_gnt != 2'b00) && plan.split) begin
			assert final (plan.first.bank != plan.second.bank)
				else $error("ERROR %0t: both lines map to bank %0d", $time, plan.first.bank);
		end
	end

endmodule

// File: verilog/mem_req_ctrl.sv
`timescale 1ns/1ps
`include "mem_req_defs.svh"

module mem_req_ctrl (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  mem_req_pkg::client_req_t                 req,
	input  logic [`NUM_BANKS-1:0]                    gnt,
	input  mem_req_pkg::line_t [`NUM_BANKS-1:0]      bank_rdata,
	output mem_req_pkg::client_rsp_t                 rsp,
	output logic [`NUM_BANKS-1:0]                    bank_req,
	output mem_req_pkg::bank_cmd_t [`NUM_BANKS-1:0]  bank_cmd
);

	mem_req_pkg::access_plan_t plan;
	logic accept;
	// per line grant pulse, first and second line
	logic [1:0] line_gnt;
	logic wr_ack;
	logic rd_valid;
	mem_req_pkg::line_t rd_data;

	// ----------------------------------------
	// request path
	// ----------------------------------------

	access_planner u_planner (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.accept(accept),
		.plan(plan)
	);

	req_sequencer u_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.plan(plan),
		.gnt(gnt),
		.accept(accept),
		.bank_req(bank_req),
		.line_gnt(line_gnt),
		.wr_ack(wr_ack)
	);

	bank_port_mux u_port_mux (
		.plan(plan),
		.line_gnt(line_gnt),
		.bank_cmd(bank_cmd)
	);

	// ----------------------------------------
	// response path
	// ----------------------------------------

	read_realign u_realign (
		.clk(clk),
		.rst_n(rst_n),
		.plan(plan),
		.line_gnt(line_gnt),
		.bank_rdata(bank_rdata),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	assign rsp = '{rd_valid: rd_valid, rd_data: rd_data, wr_ack: wr_ack};

endmodule

// File: sim/sram_bank_model.sv
`timescale 1ns/1ps
`include "mem_req_defs.svh"

module sram_bank_model (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic [`NUM_BANKS-1:0]                    bank_req,
	input  mem_req_pkg::bank_cmd_t [`NUM_BANKS-1:0]  bank_cmd,
	output logic [`NUM_BANKS-1:0]                    gnt,
	output mem_req_pkg::line_t [`NUM_BANKS-1:0]      bank_rdata
);

	localparam int MEM_BYTES = `NUM_BANKS * (1 << `LINE_ADDR_W) * `LINE_BYTES;

	// flat storage, index is {bank, line, byte}
	logic [7:0] mem [MEM_BYTES];
	// idle cycles left before the next grant of each bank
	int unsigned wait_cnt [`NUM_BANKS];
	logic [`NUM_BANKS-1:0] gnt_next;
	mem_req_pkg::line_t rdata_next [`NUM_BANKS];

	initial begin
		gnt = '0;
		bank_rdata = '0;
		for (int b = 0; b < `NUM_BANKS; b++) begin
			wait_cnt[b] = 0;
		end
		// every index bit changes the fill byte
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16) ^ 8'h3c;
		end
	end

	// sample mid cycle, drive just after the next rising edge
	always @(negedge clk) begin
		int unsigned base;
		for (int b = 0; b < `NUM_BANKS; b++) begin
			base = b * (1 << (`LINE_ADDR_W + `OFFSET_W)) + int'(bank_cmd[b].line_addr) * `LINE_BYTES;
			if (bank_cmd[b].cs && bank_cmd[b].write) begin
				for (int i = 0; i < `LINE_BYTES; i++) begin
					if (bank_cmd[b].byte_en[i]) begin
						mem[base + i] = bank_cmd[b].wdata[i];
					end
				end
			end
			// line comes back the cycle after a read grant, noise otherwise
			if (bank_cmd[b].cs && bank_cmd[b].read) begin
				for (int i = 0; i < `LINE_BYTES; i++) begin
					rdata_next[b][i] = mem[base + i];
				end
			end else begin
				for (int w = 0; w < `LINE_BYTES / 4; w++) begin
					rdata_next[b][w*4 +: 4] = $urandom;
				end
			end
			// arbiter, one grant pulse after 0..3 idle cycles
			gnt_next[b] = 1'b0;
			if (rst_n && gnt[b]) begin
				wait_cnt[b] = $urandom_range(3, 0);
			end else if (rst_n && bank_req[b]) begin
				if (wait_cnt[b] == 0) begin
					gnt_next[b] = 1'b1;
				end else begin
					wait_cnt[b] = wait_cnt[b] - 1;
				end
			end
		end
		@(posedge clk);
		#1;
		gnt = gnt_next;
		for (int b = 0; b < `NUM_BANKS; b++) begin
			bank_rdata[b] = rdata_next[b];
		end
	end

endmodule

// File: sim/tb_mem_req_ctrl.sv
`timescale 1ns/1ps
`include "mem_req_defs.svh"

module tb_mem_req_ctrl;

	localparam int NUM_TXN = 300;
	// about 60 cycles per transaction at worst
	localparam int TIMEOUT_CYCLES = NUM_TXN * 60;
	localparam int ADDR_SPAN = 1 << `ADDR_W;

	logic clk;
	logic rst_n;
	mem_req_pkg::client_req_t req;
	mem_req_pkg::client_rsp_t rsp;
	logic [`NUM_BANKS-1:0] bank_req;
	logic [`NUM_BANKS-1:0] gnt;
	mem_req_pkg::line_t [`NUM_BANKS-1:0] bank_rdata;
	mem_req_pkg::bank_cmd_t [`NUM_BANKS-1:0] bank_cmd;
	// reference memory, indexed by client byte address
	logic [7:0] ref_mem [ADDR_SPAN];
	logic [`NUM_BANKS-1:0] exp_mask;
	logic exp_split;
	logic [`NUM_BANKS-1:0] cs_on;
	logic [`NUM_BANKS-1:0] rd_cs;
	logic [`NUM_BANKS-1:0] wr_cs;
	logic last_rd_gnt;
	logic last_wr_gnt;
	logic rst_prev;
	int cycle_cnt = 0;

	mem_req_ctrl UUT (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.gnt(gnt),
		.bank_rdata(bank_rdata),
		.rsp(rsp),
		.bank_req(bank_req),
		.bank_cmd(bank_cmd)
	);

	sram_bank_model u_sram (
		.clk(clk),
		.rst_n(rst_n),
		.bank_req(bank_req),
		.bank_cmd(bank_cmd),
		.gnt(gnt),
		.bank_rdata(bank_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always_comb begin
		for (int b = 0; b < `NUM_BANKS; b++) begin
			cs_on[b] = bank_cmd[b].cs;
			rd_cs[b] = bank_cmd[b].cs && bank_cmd[b].read;
			wr_cs[b] = bank_cmd[b].cs && bank_cmd[b].write;
		end
	end

	// grant cycle that leaves no line pending
	assign last_rd_gnt = (rd_cs != '0) && ((bank_req & ~gnt) == '0);
	assign last_wr_gnt = (wr_cs != '0) && ((bank_req & ~gnt) == '0);

	always @(posedge clk) begin
		rst_prev <= rst_n;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	task automatic report_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	function automatic int unsigned map_index(input logic [`ADDR_W-1:0] a);
		return {a[`REGION_HI:`REGION_LO], a[`BANK_LO_BIT],
			a[`BANK_LO_BIT+`LINE_ADDR_W:`BANK_LO_BIT+1], a[`OFFSET_W-1:0]};
	endfunction

	function automatic logic [`BANK_W-1:0] bank_of(input logic [`ADDR_W-1:0] a);
		return {a[`REGION_HI:`REGION_LO], a[`BANK_LO_BIT]};
	endfunction

	// ----------------------------------------
	// protocol checks
	// ----------------------------------------

	assert property (@(posedge clk) (!rst_n || !rst_prev) |->
		(bank_req == '0) && (cs_on == '0) && !rsp.wr_ack && !rsp.rd_valid)
		else report_error("outputs active during or right after reset");

	// one bank per line, decoded from addr and addr + 32
	assert property (@(posedge clk) disable iff (!rst_n) $rose(|bank_req) |->
		(bank_req == exp_mask) && ($countones(bank_req) == (exp_split ? 2 : 1)))
		else report_error($sformatf("bank_req %h, expected %h", bank_req, exp_mask));

	assert property (@(posedge clk) disable iff (!rst_n)
		($past(bank_req & ~gnt) & ~bank_req) == '0)
		else report_error("bank request dropped without a grant");

	assert property (@(posedge clk) disable iff (!rst_n)
		(|bank_req) |-> !rsp.wr_ack && !rsp.rd_valid)
		else report_error("response pulse while a line waits for its grant");

	assert property (@(posedge clk) disable iff (!rst_n) last_wr_gnt |=> rsp.wr_ack)
		else report_error("wr_ack missing one cycle after the last write grant");

	assert property (@(posedge clk) disable iff (!rst_n) rsp.wr_ack |-> $past(last_wr_gnt))
		else report_error("wr_ack without a last write grant one cycle before");

	assert property (@(posedge clk) disable iff (!rst_n) last_rd_gnt |-> ##2 rsp.rd_valid)
		else report_error("rd_valid missing two cycles after the last read grant");

	assert property (@(posedge clk) disable iff (!rst_n)
		rsp.rd_valid |-> $past(last_rd_gnt, 2))
		else report_error("rd_valid without a last read grant two cycles before");

	// read wins while both requests are up
	assert property (@(posedge clk) disable iff (!rst_n)
		req.rd_req && req.wr_req |-> wr_cs == '0)
		else report_error("write granted before the read of a combined request");

	// ----------------------------------------
	// client side tasks
	// ----------------------------------------

	task automatic drive_request(input logic rd, input logic wr,
		input logic [`ADDR_W-1:0] addr, input logic [`SIZE_W-1:0] size,
		input mem_req_pkg::line_t wdata);
		@(posedge clk);
		#1;
		req.rd_req = rd;
		req.wr_req = wr;
		req.addr = addr;
		req.size = size;
		req.wdata = wdata;
		exp_split = (int'(addr[`OFFSET_W-1:0]) + int'(size)) > `LINE_BYTES;
		exp_mask = '0;
		exp_mask[bank_of(addr)] = 1'b1;
		if (exp_split) begin
			exp_mask[bank_of(addr + `ADDR_W'(`LINE_BYTES))] = 1'b1;
		end
	endtask

	task automatic drop_request();
		@(posedge clk);
		#1;
		req.rd_req = 1'b0;
		req.wr_req = 1'b0;
	endtask

	task automatic check_read(input logic [`ADDR_W-1:0] addr, input logic [`SIZE_W-1:0] size);
		mem_req_pkg::line_t exp_line;
		logic [`ADDR_W-1:0] a;
		do @(negedge clk); while (!rsp.rd_valid);
		// requested bytes from byte 0 up, zero above size
		exp_line = '0;
		for (int i = 0; i < int'(size); i++) begin
			a = addr + `ADDR_W'(i);
			exp_line[i] = ref_mem[a];
		end
		assert (rsp.rd_data == exp_line)
			else report_error($sformatf("read %h size %0d gave %h, expected %h",
				addr, size, rsp.rd_data, exp_line));
	endtask

	task automatic check_write(input logic [`ADDR_W-1:0] addr, input logic [`SIZE_W-1:0] size,
		input mem_req_pkg::line_t wdata);
		logic [`ADDR_W-1:0] a;
		logic [`ADDR_W-1:0] line_base;
		do @(negedge clk); while (!rsp.wr_ack);
		for (int i = 0; i < int'(size); i++) begin
			a = addr + `ADDR_W'(i);
			ref_mem[a] = wdata[i];
		end
		// both lines around the write, bytes outside it too
		line_base = {addr[`ADDR_W-1:`OFFSET_W], `OFFSET_W'(0)};
		for (int i = 0; i < 2 * `LINE_BYTES; i++) begin
			a = line_base + `ADDR_W'(i);
			assert (u_sram.mem[map_index(a)] == ref_mem[a])
				else report_error($sformatf("byte %h is %h after write, expected %h",
					a, u_sram.mem[map_index(a)], ref_mem[a]));
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		logic [`ADDR_W-1:0] addr;
		logic [`SIZE_W-1:0] size;
		mem_req_pkg::line_t wdata;
		int unsigned kind;
		void'($urandom(32'h41ba93fc));
		req = '0;
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int ba = 0; ba < ADDR_SPAN; ba++) begin
			ref_mem[ba] = u_sram.mem[map_index(ba)];
		end
		for (int n = 0; n < NUM_TXN; n++) begin
			addr = `ADDR_W'($urandom);
			// half the traffic in a small window so reads meet earlier writes
			if ($urandom_range(1, 0) == 0) begin
				addr[15:9] = '0;
			end
			size = `SIZE_W'($urandom_range(`LINE_BYTES, 1));
			for (int w = 0; w < `LINE_BYTES / 4; w++) begin
				wdata[w*4 +: 4] = $urandom;
			end
			kind = $urandom_range(9, 0);
			if (kind < 4) begin
				drive_request(1'b1, 1'b0, addr, size, wdata);
				check_read(addr, size);
			end else if (kind < 8) begin
				drive_request(1'b0, 1'b1, addr, size, wdata);
				check_write(addr, size, wdata);
			end else begin
				// combined, the read first and then the write alone
				drive_request(1'b1, 1'b1, addr, size, wdata);
				check_read(addr, size);
				drive_request(1'b0, 1'b1, addr, size, wdata);
				check_write(addr, size, wdata);
			end
			drop_request();
		end
		// whole memory against the reference
		for (int ba = 0; ba < ADDR_SPAN; ba++) begin
			assert (u_sram.mem[map_index(ba)] == ref_mem[ba])
				else report_error($sformatf("byte %h differs from the reference", ba));
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: compile.f
+incdir+verilog
verilog/mem_req_pkg.sv
verilog/access_planner.sv
verilog/req_sequencer.sv
verilog/read_realign.sv
verilog/bank_port_mux.sv
verilog/mem_req_ctrl.sv
sim/sram_bank_model.sv
sim/tb_mem_req_ctrl.sv
